/* verilog/bus_fabric_pkg.sv */
package bus_fabric_pkg;

  // bus widths
  localparam int ADDR_W = 16;  // word address
  localparam int DATA_W = 32;  // data word

  // memory map defaults for the top level parameters
  localparam int DEF_NUM_BANKS    = 4;    // identical ram banks
  localparam int DEF_BANK_WORDS   = 256;  // words per bank, power of two
  localparam int DEF_PROTECT_BASE = 896;  // first read-only word

  // startup contents are address + tag
  localparam logic [DATA_W-1:0] STARTUP_TAG = 32'h5A00_0000;

  // latched op in host port and strobed op into a bank
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } bus_op_t;

  // bank walk states for reads and writes
  typedef enum logic [2:0] {
    BANK_WAIT              = 3'd0,  // idle, waiting for strobe
    BANK_READ_SET_ADDRESS  = 3'd1,  // offset held, array read
    BANK_READ_DATA_GET     = 3'd2,  // data on bank_rdata, done high
    BANK_WRITE_SET_ADDRESS = 3'd3,  // offset and data held
    BANK_WRITE_SET_WE      = 3'd4,  // write enable step
    BANK_WRITE_FINISH      = 3'd5   // word stored, done high
  } bank_state_t;

  // no BANK_READ_FINISH state
  // reads go back to wait straight from data-get

endpackage

/* verilog/bus_host_port.sv */
`timescale 1ns/1ps

module bus_host_port import bus_fabric_pkg::*; #(
  parameter int NUM_BANKS    = DEF_NUM_BANKS,
  parameter int BANK_WORDS   = DEF_BANK_WORDS,
  parameter int PROTECT_BASE = DEF_PROTECT_BASE
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [ADDR_W-1:0]             addr,
  input  logic [DATA_W-1:0]             wdata,
  input  logic                          read_q,
  input  logic                          write_q,
  output logic [NUM_BANKS-1:0]          bank_sel,     // one-hot, one cycle
  output bus_op_t                       bank_op,
  output logic [$clog2(BANK_WORDS)-1:0] bank_offset,
  output logic [DATA_W-1:0]             bank_wdata,
  output logic                          skip,         // protected write
  output logic                          miss          // unmapped address
);

  localparam int OFF_W = $clog2(BANK_WORDS);
  localparam int unsigned MAP_END = NUM_BANKS * BANK_WORDS;  // first unmapped word

  logic              busy;       // blocks sampling until both requests drop
  logic              pend;       // sampled last edge, issue this edge
  logic [ADDR_W-1:0] req_addr;
  logic [DATA_W-1:0] req_wdata;
  bus_op_t           req_op;
  logic              any_q;
  logic              take;
  logic              mapped;
  logic              protect;
  logic [ADDR_W-OFF_W-1:0] bank_idx;

  assign any_q = read_q | write_q;
  assign take  = ~busy & any_q;  // sampling edge

  // address classification off the latched request
  assign mapped   = 32'(req_addr) < MAP_END;
  assign protect  = 32'(req_addr) >= 32'(PROTECT_BASE);
  assign bank_idx = req_addr[ADDR_W-1:OFF_W];  // addr / BANK_WORDS

  // shared lines to every bank, held for the whole transaction
  assign bank_op     = req_op;
  assign bank_offset = req_addr[OFF_W-1:0];  // addr % BANK_WORDS
  assign bank_wdata  = req_wdata;

  // request payload
  always_ff @(posedge clk) begin
    if (take) begin
      req_addr  <= addr;
      req_wdata <= wdata;
      req_op    <= write_q ? OP_WRITE : OP_READ;  // one request at a time
    end
  end

  // sample, issue, wait for four-phase return to idle
  always_ff @(posedge clk) begin
    if (rst) begin
      busy     <= 1'b0;
      pend     <= 1'b0;
      bank_sel <= '0;
      skip     <= 1'b0;
      miss     <= 1'b0;
    end else begin
      bank_sel <= '0;  // pulses by default
      skip     <= 1'b0;
      miss     <= 1'b0;
      pend     <= 1'b0;
      if (take) begin
        busy <= 1'b1;
        pend <= 1'b1;
      end else if (pend) begin
        if (!mapped) begin
          miss <= 1'b1;  // nobody answers this one
        end else if (req_op == OP_WRITE && protect) begin
          skip <= 1'b1;  // read-only region, done without change
        end else begin
          bank_sel <= NUM_BANKS'(1) << bank_idx;
        end
      end else if (busy && !any_q) begin
        busy <= 1'b0;  // requester dropped, done falls this edge too
      end
    end
  end

endmodule

/* verilog/ram_bank.sv */
`timescale 1ns/1ps

module ram_bank import bus_fabric_pkg::*; #(
  parameter int BANK_INDEX = 0,
  parameter int BANK_WORDS = DEF_BANK_WORDS
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          bank_sel,     // this bank's strobe
  input  bus_op_t                       bank_op,
  input  logic [$clog2(BANK_WORDS)-1:0] bank_offset,
  input  logic [DATA_W-1:0]             bank_wdata,
  output logic                          bank_done,
  output logic [DATA_W-1:0]             bank_rdata    // zero outside done
);

  localparam int OFF_W = $clog2(BANK_WORDS);

  logic [DATA_W-1:0] mem [BANK_WORDS];
  bank_state_t       state;
  logic [OFF_W-1:0]  off_q;    // captured offset
  logic [DATA_W-1:0] data_q;   // captured write data
  logic [DATA_W-1:0] rd_word;  // array read result

  // startup contents, global address plus tag
  initial begin
    for (int i = 0; i < BANK_WORDS; i++) begin
      mem[i] = DATA_W'(BANK_INDEX * BANK_WORDS + i) + STARTUP_TAG;
    end
  end

  // OR-merge downstream needs zeros from idle banks
  assign bank_rdata = bank_done ? rd_word : '0;

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= BANK_WAIT;
      bank_done <= 1'b0;
    end else begin
      bank_done <= 1'b0;
      case (state)
        BANK_WAIT: begin
          if (bank_sel) begin
            state <= (bank_op == OP_WRITE) ? BANK_WRITE_SET_ADDRESS
                                           : BANK_READ_SET_ADDRESS;
          end
        end
        BANK_READ_SET_ADDRESS: begin
          state     <= BANK_READ_DATA_GET;
          bank_done <= 1'b1;  // 2 cycles after strobe edge
        end
        BANK_READ_DATA_GET: state <= BANK_WAIT;
        BANK_WRITE_SET_ADDRESS: state <= BANK_WRITE_SET_WE;
        BANK_WRITE_SET_WE: begin
          state     <= BANK_WRITE_FINISH;
          bank_done <= 1'b1;  // 3 cycles after strobe edge
        end
        BANK_WRITE_FINISH: state <= BANK_WAIT;
        default: state <= BANK_WAIT;
      endcase
    end
  end

  // address and data capture at set-address
  always_ff @(posedge clk) begin
    if (state == BANK_WAIT && bank_sel) begin
      off_q  <= bank_offset;
      data_q <= bank_wdata;
    end
  end

  // array port
  always @(posedge clk) begin
    if (state == BANK_READ_SET_ADDRESS)
      rd_word <= mem[off_q];  // lands with bank_done
    if (state == BANK_WRITE_FINISH)
      mem[off_q] <= data_q;   // store in finish
  end

endmodule

/* verilog/bus_return_merge.sv */
`timescale 1ns/1ps

module bus_return_merge import bus_fabric_pkg::*; #(
  parameter int NUM_BANKS = DEF_NUM_BANKS
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        read_q,
  input  logic                        write_q,
  input  logic [NUM_BANKS-1:0]        bank_done_all,
  input  logic [NUM_BANKS*DATA_W-1:0] bank_rdata_all,
  input  logic                        skip,
  input  logic                        miss,
  output logic [DATA_W-1:0]           rdata,
  output logic                        read_dn,
  output logic                        write_dn,
  output logic                        bus_err
);

  logic [DATA_W-1:0] merged_data;  // OR of all bank returns
  logic              merged_done;  // any responder finished
  logic              finish;

  // idle banks return zeros, so OR picks the active one
  always_comb begin
    merged_data = '0;
    for (int b = 0; b < NUM_BANKS; b++) begin
      merged_data = merged_data | bank_rdata_all[b*DATA_W +: DATA_W];
    end
  end

  assign merged_done = |bank_done_all;
  assign finish      = merged_done | skip | miss;  // skip and miss need no bank

  // read data register, only loaded with a finish
  always_ff @(posedge clk) begin
    if (finish)
      rdata <= merged_data;  // zero on skip or miss
  end

  // done side of the four-phase handshake
  always_ff @(posedge clk) begin
    if (rst) begin
      read_dn  <= 1'b0;
      write_dn <= 1'b0;
      bus_err  <= 1'b0;
    end else if (finish) begin
      read_dn  <= read_q;   // match whichever request is up
      write_dn <= write_q;
      bus_err  <= miss;
    end else if (!read_q && !write_q) begin
      read_dn  <= 1'b0;     // request seen low, drop done
      write_dn <= 1'b0;
      bus_err  <= 1'b0;
    end
    // otherwise hold, requester may keep its request past done
  end

endmodule

/* verilog/bus_fabric_top.sv */
`timescale 1ns/1ps

module bus_fabric_top import bus_fabric_pkg::*; #(
  parameter int NUM_BANKS    = DEF_NUM_BANKS,
  parameter int BANK_WORDS   = DEF_BANK_WORDS,
  parameter int PROTECT_BASE = DEF_PROTECT_BASE
) (
  input  logic              clk,
  input  logic              rst,
  input  logic [ADDR_W-1:0] addr,
  input  logic [DATA_W-1:0] wdata,
  input  logic              read_q,
  input  logic              write_q,
  output logic [DATA_W-1:0] rdata,
  output logic              read_dn,
  output logic              write_dn,
  output logic              bus_err
);

  localparam int OFF_W = $clog2(BANK_WORDS);

  // host port to banks
  logic [NUM_BANKS-1:0]        bank_sel;
  bus_op_t                     bank_op;
  logic [OFF_W-1:0]            bank_offset;
  logic [DATA_W-1:0]           bank_wdata;
  // host port to merge
  logic                        skip;
  logic                        miss;
  // banks to merge
  logic [NUM_BANKS-1:0]        bank_done_all;
  logic [NUM_BANKS*DATA_W-1:0] bank_rdata_all;

  bus_host_port #(
    .NUM_BANKS    (NUM_BANKS),
    .BANK_WORDS   (BANK_WORDS),
    .PROTECT_BASE (PROTECT_BASE)
  ) u_host (
    .clk         (clk),
    .rst         (rst),
    .addr        (addr),
    .wdata       (wdata),
    .read_q      (read_q),
    .write_q     (write_q),
    .bank_sel    (bank_sel),
    .bank_op     (bank_op),
    .bank_offset (bank_offset),
    .bank_wdata  (bank_wdata),
    .skip        (skip),
    .miss        (miss)
  );

  // one bank per slice of the map
  for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
    ram_bank #(
      .BANK_INDEX (i),
      .BANK_WORDS (BANK_WORDS)
    ) u_bank (
      .clk         (clk),
      .rst         (rst),
      .bank_sel    (bank_sel[i]),
      .bank_op     (bank_op),
      .bank_offset (bank_offset),
      .bank_wdata  (bank_wdata),
      .bank_done   (bank_done_all[i]),
      .bank_rdata  (bank_rdata_all[i*DATA_W +: DATA_W])
    );
  end

  bus_return_merge #(
    .NUM_BANKS (NUM_BANKS)
  ) u_merge (
    .clk            (clk),
    .rst            (rst),
    .read_q         (read_q),
    .write_q        (write_q),
    .bank_done_all  (bank_done_all),
    .bank_rdata_all (bank_rdata_all),
    .skip           (skip),
    .miss           (miss),
    .rdata          (rdata),
    .read_dn        (read_dn),
    .write_dn       (write_dn),
    .bus_err        (bus_err)
  );

endmodule

/* verif/bus_fabric_properties.sv */
`timescale 1ns/1ps

module bus_fabric_properties #(
  parameter int NUM_BANKS = 4
) (
  input logic                 clk,
  input logic                 rst,
  input logic                 read_q,
  input logic                 write_q,
  input logic                 read_dn,
  input logic                 write_dn,
  input logic                 bus_err,
  input logic [NUM_BANKS-1:0] bank_sel  // host port strobe
);

  // only one kind of done at a time
  a_one_done: assert property (@(posedge clk) disable iff (rst)
    !(read_dn && write_dn))
    else $error("read_dn and write_dn high together");

  // done holds until its request is seen low
  a_read_hold: assert property (@(posedge clk) disable iff (rst)
    (read_dn && read_q) |=> read_dn)
    else $error("read_dn fell while read_q was high");
  a_write_hold: assert property (@(posedge clk) disable iff (rst)
    (write_dn && write_q) |=> write_dn)
    else $error("write_dn fell while write_q was high");

  a_err_with_done: assert property (@(posedge clk) disable iff (rst)
    bus_err |-> (read_dn || write_dn))  // error only rides on a done
    else $error("bus_err high without a done");

  a_sel_onehot: assert property (@(posedge clk) disable iff (rst)
    $onehot0(bank_sel))
    else $error("more than one bank strobed");

endmodule

// hooked onto every fabric top
bind bus_fabric_top bus_fabric_properties #(
  .NUM_BANKS (NUM_BANKS)
) u_props (
  .clk      (clk),
  .rst      (rst),
  .read_q   (read_q),
  .write_q  (write_q),
  .read_dn  (read_dn),
  .write_dn (write_dn),
  .bus_err  (bus_err),
  .bank_sel (bank_sel)
);

/* verif/bus_fabric_tb.sv */
`timescale 1ns/1ps

module bus_fabric_tb;

  localparam int NUM_BANKS    = 4;
  localparam int BANK_WORDS   = 256;
  localparam int PROTECT_BASE = 896;                     // first read-only word
  localparam int MAP_WORDS    = NUM_BANKS * BANK_WORDS;  // first unmapped word
  localparam int MAP_AW       = $clog2(MAP_WORDS);
  localparam logic [31:0] TAG = 32'h5A00_0000;           // startup word = addr + tag
  // about 300 transactions at up to 20 cycles each
  localparam int TIMEOUT_CYCLES = 300 * 20;

  logic        clk;
  logic        rst;
  logic [15:0] addr;
  logic [31:0] wdata;
  logic        read_q;
  logic        write_q;
  logic [31:0] rdata;
  logic        read_dn;
  logic        write_dn;
  logic        bus_err;

  logic [31:0] shadow [MAP_WORDS];  // reference copy of the whole map
  logic [31:0] rng;
  int          cycles;
  int          value_errs;
  int          proto_errs;
  int          checked;

  // one entry per issued request until its done rises
  logic [32:0] exp_q [$];     // {bus_err, rdata}
  logic        exp_wr_q [$];
  string       name_q [$];

  logic        dn_prev;       // done seen high last negedge
  logic [31:0] held_rdata;
  logic        held_err;
  logic        held_rd;
  string       cur_name;

  bus_fabric_top #(
    .NUM_BANKS    (NUM_BANKS),
    .BANK_WORDS   (BANK_WORDS),
    .PROTECT_BASE (PROTECT_BASE)
  ) DUT (
    .clk      (clk),
    .rst      (rst),
    .addr     (addr),
    .wdata    (wdata),
    .read_q   (read_q),
    .write_q  (write_q),
    .rdata    (rdata),
    .read_dn  (read_dn),
    .write_dn (write_dn),
    .bus_err  (bus_err)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;  // 100 ns period
  end

  // xorshift32
  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  // expected {bus_err, rdata} for one access
  function automatic logic [32:0] predict_access(input logic is_wr, input int unsigned a,
                                                 input logic [31:0] d);
    if (a >= MAP_WORDS)
      return {1'b1, 32'h0};  // unmapped with zero read data
    if (is_wr) begin
      if (a < PROTECT_BASE)
        shadow[MAP_AW'(a)] = d;  // protected region keeps its word
      return {1'b0, 32'h0};      // rdata not checked on writes
    end
    return {1'b0, shadow[MAP_AW'(a)]};
  endfunction

  // one four-phase transaction
  // hold counts the extra cycles the request stays up after done
  task automatic do_txn(input logic is_wr, input int unsigned a, input logic [31:0] d,
                        input int hold, input string name);
    @(posedge clk);
    addr    <= 16'(a);
    wdata   <= d;
    read_q  <= ~is_wr;
    write_q <= is_wr;
    exp_q.push_back(predict_access(is_wr, a, d));
    exp_wr_q.push_back(is_wr);
    name_q.push_back(name);
    do @(posedge clk); while (!(read_dn || write_dn));
    repeat (hold) @(posedge clk);
    read_q  <= 1'b0;
    write_q <= 1'b0;
    do @(posedge clk); while (read_dn || write_dn);  // back to idle
  endtask

  task automatic read_word(input int unsigned a, input int hold, input string name);
    do_txn(1'b0, a, 32'h0, hold, name);
  endtask

  task automatic write_word(input int unsigned a, input logic [31:0] d, input int hold,
                            input string name);
    do_txn(1'b1, a, d, hold, name);
  endtask

  // compare process samples outputs mid-cycle
  always @(negedge clk) begin
    logic [32:0] exp_val;
    logic        exp_wr;
    if (rst) begin
      dn_prev = 1'b0;
    end else if ($isunknown(read_dn) || $isunknown(write_dn) || $isunknown(bus_err)) begin
      $display("done or bus_err is unknown out of reset");
      proto_errs++;
    end else if (read_dn || write_dn) begin
      if (!dn_prev) begin
        if (exp_q.size() == 0) begin
          $display("done rose with no request outstanding");
          proto_errs++;
        end else begin
          exp_val  = exp_q.pop_front();
          exp_wr   = exp_wr_q.pop_front();
          cur_name = name_q.pop_front();
          checked++;
          if (read_dn == exp_wr || write_dn != exp_wr) begin
            $display("%s: the done line does not match the request", cur_name);
            proto_errs++;
          end
          if (bus_err !== exp_val[32]) begin
            $display("FAILED %s bus_err expected %0b actual %0b", cur_name, exp_val[32],
                     bus_err);
            value_errs++;
          end
          if (!exp_wr && rdata !== exp_val[31:0]) begin
            $display("FAILED %s rdata expected %h actual %h", cur_name, exp_val[31:0],
                     rdata);
            value_errs++;
          end
        end
        held_rdata = rdata;  // must stay put while request held
        held_err   = bus_err;
        held_rd    = read_dn;
      end else if (rdata !== held_rdata || bus_err !== held_err || read_dn !== held_rd) begin
        $display("FAILED %s held done expected rdata %h err %0b actual rdata %h err %0b",
                 cur_name, held_rdata, held_err, rdata, bus_err);
        value_errs++;
      end
      dn_prev = 1'b1;
    end else begin
      if (dn_prev && (read_q || write_q)) begin
        $display("%s: done dropped while the request was still held", cur_name);
        proto_errs++;
      end
      if (bus_err) begin
        $display("bus_err is high with no done");
        proto_errs++;
      end
      dn_prev = 1'b0;
    end
  end

  // cycle limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, the DUT stopped completing requests", cycles);
      $display("Verification failed");
      $finish;
    end
  end

  initial begin
    int unsigned a;
    logic [31:0] d;
    int          hold;
    rst     = 1'b1;
    addr    = '0;
    wdata   = '0;
    read_q  = 1'b0;
    write_q = 1'b0;
    rng     = 32'd23859;
    for (int i = 0; i < MAP_WORDS; i++)
      shadow[MAP_AW'(i)] = 32'(i) + TAG;  // startup rule
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    repeat (8) @(posedge clk);  // idle cycles where any stray done is flagged

    // startup contents at both ends and a few inside each bank
    for (int b = 0; b < NUM_BANKS; b++) begin
      read_word(b * BANK_WORDS, 0, "startup_first");
      read_word(b * BANK_WORDS + BANK_WORDS - 1, 0, "startup_last");
      repeat (4) read_word(b * BANK_WORDS + next_rand() % BANK_WORDS, 0, "startup_random");
    end

    // writes below the protected region with read back
    for (int n = 0; n < 40; n++) begin
      a = next_rand() % PROTECT_BASE;
      d = next_rand();
      write_word(a, d, 0, "write");
      read_word(a, 0, "readback");
    end
    for (int n = 0; n < 24; n++)
      read_word(next_rand() % PROTECT_BASE, 0, "reread");  // mix of touched and startup

    // protected region
    write_word(PROTECT_BASE, 32'hDEAD_BEEF, 0, "protect_base_write");
    read_word(PROTECT_BASE, 0, "protect_base_read");
    write_word(MAP_WORDS - 1, 32'h1234_5678, 0, "protect_top_write");
    read_word(MAP_WORDS - 1, 0, "protect_top_read");
    for (int n = 0; n < 10; n++) begin
      a = PROTECT_BASE + next_rand() % (MAP_WORDS - PROTECT_BASE);
      write_word(a, next_rand(), 0, "protect_write");
      read_word(a, 0, "protect_read");
    end

    // unmapped addresses
    read_word(MAP_WORDS, 0, "unmapped_read_low");
    write_word(MAP_WORDS, 32'hFFFF_FFFF, 0, "unmapped_write_low");
    read_word(65535, 0, "unmapped_read_high");
    write_word(65535, 32'hA5A5_A5A5, 0, "unmapped_write_high");
    for (int n = 0; n < 8; n++) begin
      a = MAP_WORDS + next_rand() % (65536 - MAP_WORDS);
      d = next_rand();
      if (d[0])
        write_word(a, d, 0, "unmapped_write");
      else
        read_word(a, 0, "unmapped_read");
    end

    // held requests on mostly mapped words with a few misses
    for (int n = 0; n < 30; n++) begin
      d    = next_rand();
      a    = next_rand() % (MAP_WORDS + 64);
      hold = next_rand() % 6;
      if (d[0])
        write_word(a, d, hold, "held_write");
      else
        read_word(a, hold, "held_read");
    end

    repeat (3) @(posedge clk);
    @(negedge clk);
    $display("checked %0d transactions, %0d value errors, %0d protocol errors, %0d pending",
             checked, value_errs, proto_errs, exp_q.size());
    if (value_errs == 0 && proto_errs == 0 && exp_q.size() == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* tb.f */
verilog/bus_fabric_pkg.sv
verilog/bus_host_port.sv
verilog/ram_bank.sv
verilog/bus_return_merge.sv
verilog/bus_fabric_top.sv
verif/bus_fabric_properties.sv
verif/bus_fabric_tb.sv

/* Makefile */
TOP = bus_fabric_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f tb.f -Mdir obj_dir

# pass only if the pass line shows up in the simulation output
run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf obj_dir
